//--- build.f
rtl/imuldiv_pkg.sv
rtl/int_mul_dpath.sv
rtl/int_mul_ctrl.sv
rtl/int_mul_iterative.sv
rtl/int_div_iterative.sv
rtl/imuldiv_unit.sv
verification/imuldiv_properties.sv
verification/tb_imuldiv.sv

//--- verification/tb_imuldiv.sv
// ------------------------------------------------
// testbench for the integer multiply/divide unit
// seeded random requests checked against a behavioral model
// ------------------------------------------------

`timescale 1ns/100ps

module tb_imuldiv;

  localparam int dw = imuldiv_pkg::data_width;
  // about 200 transactions at up to 50 cycles each, doubled for margin
  localparam int cycle_limit = 200 * 50 * 2;

  logic                                 clk = 1'b0;
  logic                                 reset;
  imuldiv_pkg::muldiv_op_e              req_op;
  logic [dw-1:0]                        req_a;
  logic [dw-1:0]                        req_b;
  logic                                 req_val;
  logic                                 resp_rdy;
  logic                                 req_rdy;
  logic [imuldiv_pkg::result_width-1:0] resp_result;
  logic                                 resp_val;

  integer seed = 52;
  int     cycle_count = 0;
  int     txn_count = 0;
  int     error_count = 0;
  logic [imuldiv_pkg::result_width-1:0] expected_q[$];

  // most negative, neg x neg, zero, all ones, max positive
  logic [dw-1:0] corner_a[8] = '{32'h8000_0000, 32'h8000_0000, 32'hffff_ffff, 32'hffff_fff9,
                                 32'h0000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000};
  logic [dw-1:0] corner_b[8] = '{32'h8000_0000, 32'h0000_0001, 32'hffff_ffff, 32'hffff_fffd,
                                 32'h1234_5678, 32'h0000_0000, 32'h7fff_ffff, 32'hffff_ffff};

  imuldiv_unit imuldiv_unit_i (
    .clk         (clk),
    .reset       (reset),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .resp_rdy    (resp_rdy),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val)
  );

  always #2 clk = ~clk;

  // watchdog
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("run did not finish within %0d cycles, a response never arrived", cycle_limit);
      $display("Testbench failed");
      $finish;
    end
  end

  // ------------------------------------------------
  // reference model
  // ------------------------------------------------

  // product, or {remainder, quotient}, worked out on magnitudes
  function automatic logic [63:0] model_result(input imuldiv_pkg::muldiv_op_e op,
                                               input logic [dw-1:0] a,
                                               input logic [dw-1:0] b);
    logic        is_signed;
    logic        a_neg;
    logic        b_neg;
    logic [63:0] mag_a;
    logic [63:0] mag_b;
    logic [63:0] prod;
    logic [63:0] quot;
    logic [63:0] rem;
    is_signed = (op == imuldiv_pkg::op_mul) || (op == imuldiv_pkg::op_div);
    a_neg = is_signed && a[dw-1];
    b_neg = is_signed && b[dw-1];
    // |x| = 2^32 - x for a negative 32-bit value
    mag_a = a_neg ? (64'd1 << dw) - {32'd0, a} : {32'd0, a};
    mag_b = b_neg ? (64'd1 << dw) - {32'd0, b} : {32'd0, b};
    if (op == imuldiv_pkg::op_mul || op == imuldiv_pkg::op_mulu) begin
      prod = mag_a * mag_b;
      return (a_neg ^ b_neg) ? -prod : prod;
    end
    quot = mag_a / mag_b;
    rem  = mag_a % mag_b;
    // quotient sign from both operands, remainder sign from dividend
    if (a_neg ^ b_neg) begin
      quot = -quot;
    end
    if (a_neg) begin
      rem = -rem;
    end
    return {rem[dw-1:0], quot[dw-1:0]};
  endfunction

  // mostly small divisors so quotients get wide
  function automatic logic [dw-1:0] random_divisor();
    logic [dw-1:0] d;
    d = ($random(seed) & 1) ? $random(seed) : ($random(seed) & 32'h0000_00ff);
    if (d == '0) begin
      d = 32'd1;
    end
    return d;
  endfunction

  // ------------------------------------------------
  // scoreboard, one compare per response handshake
  // ------------------------------------------------

  always @(posedge clk) begin : scoreboard
    logic [imuldiv_pkg::result_width-1:0] expected_result;
    if (!reset && resp_val && resp_rdy) begin
      if (expected_q.size() == 0) begin
        $display("ERROR at %0t: response arrived with no request outstanding", $time);
        error_count++;
      end else begin
        expected_result = expected_q.pop_front();
        if (resp_result !== expected_result) begin
          $display("CHECK FAILED at %0t: %s a=%h b=%h result %h, expected %h", $time,
                   req_op.name(), req_a, req_b, resp_result, expected_result);
          error_count++;
        end
      end
    end
  end

  // ------------------------------------------------
  // one transaction, called and returning on a falling edge
  // ------------------------------------------------

  task automatic run_transaction(input imuldiv_pkg::muldiv_op_e op, input logic [dw-1:0] a,
                                 input logic [dw-1:0] b, input logic back_pressure);
    int   latency;
    logic done;
    if (resp_val) begin
      $display("ERROR at %0t: resp_val high with no transaction in flight", $time);
      error_count++;
    end
    req_op  = op;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    expected_q.push_back(model_result(op, a, b));
    txn_count++;
    // req_rdy depends on unit state only, settled at the falling edge
    while (!req_rdy) begin
      @(negedge clk);
    end
    @(negedge clk);
    req_val = 1'b0;
    latency = 1;
    while (!resp_val) begin
      if (req_rdy) begin
        $display("ERROR at %0t: req_rdy high while a transaction is in flight", $time);
        error_count++;
      end
      // consumer readiness wanders even before a response shows up
      if (back_pressure) begin
        resp_rdy = ($random(seed) & 1);
      end
      @(negedge clk);
      latency++;
    end
    if (latency != imuldiv_pkg::unit_latency) begin
      $display("CHECK FAILED at %0t: latency %0d cycles, expected %0d", $time, latency,
               imuldiv_pkg::unit_latency);
      error_count++;
    end
    done = 1'b0;
    while (!done) begin
      if (req_rdy) begin
        $display("ERROR at %0t: req_rdy high before the response handshake", $time);
        error_count++;
      end
      resp_rdy = back_pressure ? (($random(seed) & 3) != 0) : 1'b1;
      // handshake lands on the next rising edge
      done = resp_rdy;
      @(negedge clk);
    end
    resp_rdy = 1'b0;
  endtask

  task automatic report_test(input string name, input int txn_before, input int err_before);
    $display("test %s done: %0d transactions, %0d errors", name, txn_count - txn_before,
             error_count - err_before);
  endtask

  // ------------------------------------------------
  // test sequence
  // ------------------------------------------------

  initial begin
    int                      i;
    int                      t0;
    int                      e0;
    int                      total_errors;
    imuldiv_pkg::muldiv_op_e op;
    logic [dw-1:0]           a;
    logic [dw-1:0]           b;
    reset    = 1'b1;
    req_op   = imuldiv_pkg::op_mul;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    if (!req_rdy || resp_val) begin
      $display("ERROR at %0t: unit not idle after reset", $time);
      error_count++;
    end

    t0 = txn_count;
    e0 = error_count;
    for (i = 0; i < 8; i++) begin
      run_transaction(imuldiv_pkg::op_mul, corner_a[i], corner_b[i], 1'b0);
      run_transaction(imuldiv_pkg::op_mulu, corner_a[i], corner_b[i], 1'b0);
    end
    report_test("mul_corners", t0, e0);

    t0 = txn_count;
    e0 = error_count;
    for (i = 0; i < 50; i++) begin
      op = ($random(seed) & 1) ? imuldiv_pkg::op_mulu : imuldiv_pkg::op_mul;
      a  = $random(seed);
      b  = $random(seed);
      run_transaction(op, a, b, 1'b0);
    end
    report_test("mul_random", t0, e0);

    t0 = txn_count;
    e0 = error_count;
    for (i = 0; i < 50; i++) begin
      op = ($random(seed) & 1) ? imuldiv_pkg::op_divu : imuldiv_pkg::op_div;
      a  = $random(seed);
      b  = random_divisor();
      run_transaction(op, a, b, 1'b0);
    end
    report_test("div_random", t0, e0);

    // any op, consumer stalls at random
    t0 = txn_count;
    e0 = error_count;
    for (i = 0; i < 80; i++) begin
      op = imuldiv_pkg::muldiv_op_e'($random(seed) & 3);
      a  = $random(seed);
      if (op == imuldiv_pkg::op_div || op == imuldiv_pkg::op_divu) begin
        b = random_divisor();
      end else begin
        b = $random(seed);
      end
      run_transaction(op, a, b, 1'b1);
    end
    report_test("mixed_backpressure", t0, e0);

    if (expected_q.size() != 0) begin
      $display("ERROR: %0d expected results were never returned", expected_q.size());
      error_count++;
    end
    total_errors = error_count + imuldiv_unit_i.props_i.assert_fail_count;
    $display("summary: %0d transactions, %0d testbench errors, %0d assertion failures",
             txn_count, error_count, imuldiv_unit_i.props_i.assert_fail_count);
    if (total_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- verification/imuldiv_properties.sv
// ------------------------------------------------
// handshake and latency assertions on the imuldiv top level
// ------------------------------------------------

`timescale 1ns/100ps

module imuldiv_properties (
  input logic                                 clk,
  input logic                                 reset,
  input logic                                 req_val,
  input logic                                 req_rdy,
  input logic                                 resp_val,
  input logic                                 resp_rdy,
  input logic [imuldiv_pkg::result_width-1:0] resp_result
);

  // count of assertion failures over the run
  int assert_fail_count = 0;

  // response held while the consumer stalls
  resp_hold_a: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_result))
  else begin
    $error("resp_val or resp_result changed under back-pressure");
    assert_fail_count++;
  end

  // no new request taken while a response is pending
  rdy_low_a: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> !req_rdy)
  else begin
    $error("req_rdy high while resp_val is high");
    assert_fail_count++;
  end

  // first resp_val exactly unit_latency cycles after the accept edge
  latency_a: assert property (@(posedge clk) disable iff (reset)
    req_val && req_rdy |=> (!resp_val)[*imuldiv_pkg::unit_latency-1] ##1 resp_val)
  else begin
    $error("resp_val did not rise exactly unit_latency cycles after accept");
    assert_fail_count++;
  end

  reset_a: assert property (@(posedge clk) reset |=> !resp_val)
  else begin
    $error("resp_val high right after reset");
    assert_fail_count++;
  end

endmodule

bind imuldiv_unit imuldiv_properties props_i (
  .clk         (clk),
  .reset       (reset),
  .req_val     (req_val),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result)
);

//--- rtl/imuldiv_unit.sv
// ------------------------------------------------
// integer multiply/divide unit top level
// routes requests by opcode and returns the owner's response
// ------------------------------------------------

`timescale 1ns/100ps

module imuldiv_unit (
  input  logic                                  clk,
  input  logic                                  reset,
  input  imuldiv_pkg::muldiv_op_e               req_op,
  input  logic [imuldiv_pkg::data_width-1:0]    req_a,
  input  logic [imuldiv_pkg::data_width-1:0]    req_b,
  input  logic                                  req_val,
  input  logic                                  resp_rdy,
  output logic                                  req_rdy,
  output logic [imuldiv_pkg::result_width-1:0]  resp_result,
  output logic                                  resp_val
);

  logic is_div;
  logic is_signed;
  logic owner_div;

  logic mul_req_rdy;
  logic mul_resp_val;
  logic [imuldiv_pkg::result_width-1:0] mul_resp_result;
  logic div_req_rdy;
  logic div_resp_val;
  logic [imuldiv_pkg::result_width-1:0] div_resp_result;

  // ------------------------------------------------
  // opcode decode and request steering
  // ------------------------------------------------

  assign is_div    = (req_op == imuldiv_pkg::op_div) || (req_op == imuldiv_pkg::op_divu);
  assign is_signed = (req_op == imuldiv_pkg::op_mul) || (req_op == imuldiv_pkg::op_div);

  // both idle before anything new comes in
  assign req_rdy = mul_req_rdy && div_req_rdy;

  // owner of the transaction in flight
  always_ff @(posedge clk) begin
    if (reset) begin
      owner_div <= 1'b0;
    end else if (req_val && req_rdy) begin
      owner_div <= is_div;
    end
  end

  // response comes only from the owner
  assign resp_val    = owner_div ? div_resp_val : mul_resp_val;
  assign resp_result = owner_div ? div_resp_result : mul_resp_result;

  // a unit sees valid only on a top-level transfer
  int_mul_iterative mul_i (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_signed  (is_signed),
    .req_val     (req_val && req_rdy && !is_div),
    .resp_rdy    (resp_rdy && !owner_div),
    .req_rdy     (mul_req_rdy),
    .resp_result (mul_resp_result),
    .resp_val    (mul_resp_val)
  );

  int_div_iterative div_i (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_signed  (is_signed),
    .req_val     (req_val && req_rdy && is_div),
    .resp_rdy    (resp_rdy && owner_div),
    .req_rdy     (div_req_rdy),
    .resp_result (div_resp_result),
    .resp_val    (div_resp_val)
  );

endmodule

//--- rtl/int_div_iterative.sv
// ------------------------------------------------
// iterative restoring divider
// returns {remainder, quotient} after 32 steps and a sign fix
// ------------------------------------------------

`timescale 1ns/100ps

module int_div_iterative (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [imuldiv_pkg::data_width-1:0]    req_a,
  input  logic [imuldiv_pkg::data_width-1:0]    req_b,
  input  logic                                  req_signed,
  input  logic                                  req_val,
  input  logic                                  resp_rdy,
  output logic                                  req_rdy,
  output logic [imuldiv_pkg::result_width-1:0]  resp_result,
  output logic                                  resp_val
);

  imuldiv_pkg::unit_state_e state;

  logic [imuldiv_pkg::data_width-1:0]    quot_reg;
  logic [imuldiv_pkg::data_width-1:0]    rem_reg;
  logic [imuldiv_pkg::data_width-1:0]    divisor_reg;
  logic [imuldiv_pkg::counter_width-1:0] counter_reg;
  logic                                  neg_quot_reg;
  logic                                  neg_rem_reg;

  logic                                  a_neg;
  logic                                  b_neg;
  logic                                  accept;
  logic [imuldiv_pkg::data_width:0]      rem_shift;
  logic [imuldiv_pkg::data_width:0]      trial_diff;

  assign a_neg  = req_signed && req_a[imuldiv_pkg::data_width-1];
  assign b_neg  = req_signed && req_b[imuldiv_pkg::data_width-1];
  assign accept = req_val && (state == imuldiv_pkg::st_idle);

  // ------------------------------------------------
  // one restoring step
  // ------------------------------------------------

  // bring down the next dividend bit, it sits at the top of quot_reg
  assign rem_shift  = {rem_reg, quot_reg[imuldiv_pkg::data_width-1]};
  // extra top bit acts as the borrow flag
  assign trial_diff = rem_shift - {1'b0, divisor_reg};

  assign req_rdy     = (state == imuldiv_pkg::st_idle);
  assign resp_val    = (state == imuldiv_pkg::st_done);
  assign resp_result = {rem_reg, quot_reg};

  // control state
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::st_idle;
    end else begin
      case (state)
        imuldiv_pkg::st_idle: if (accept)             state <= imuldiv_pkg::st_calc;
        imuldiv_pkg::st_calc: if (counter_reg == '0)  state <= imuldiv_pkg::st_sign;
        imuldiv_pkg::st_sign:                         state <= imuldiv_pkg::st_done;
        imuldiv_pkg::st_done: if (resp_rdy)           state <= imuldiv_pkg::st_idle;
        default:                                      state <= imuldiv_pkg::st_idle;
      endcase
    end
  end

  // step counter and sign flags
  always_ff @(posedge clk) begin
    if (reset) begin
      counter_reg  <= '0;
      neg_quot_reg <= 1'b0;
      neg_rem_reg  <= 1'b0;
    end else if (accept) begin
      counter_reg  <= imuldiv_pkg::counter_width'(imuldiv_pkg::step_count - 1);
      // quotient sign is xor of signs, remainder follows dividend
      neg_quot_reg <= a_neg ^ b_neg;
      neg_rem_reg  <= a_neg;
    end else if (state == imuldiv_pkg::st_calc) begin
      counter_reg <= counter_reg - 1'b1;
    end
  end

  // ------------------------------------------------
  // payload registers
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    case (state)
      imuldiv_pkg::st_idle: begin
        if (accept) begin
          // quot_reg starts as the dividend magnitude and fills with quotient bits
          quot_reg    <= a_neg ? -req_a : req_a;
          divisor_reg <= b_neg ? -req_b : req_b;
          rem_reg     <= '0;
        end
      end
      imuldiv_pkg::st_calc: begin
        if (!trial_diff[imuldiv_pkg::data_width]) begin
          // no borrow, keep the difference
          rem_reg  <= trial_diff[imuldiv_pkg::data_width-1:0];
          quot_reg <= {quot_reg[imuldiv_pkg::data_width-2:0], 1'b1};
        end else begin
          // restore, partial remainder is just the shifted value
          rem_reg  <= rem_shift[imuldiv_pkg::data_width-1:0];
          quot_reg <= {quot_reg[imuldiv_pkg::data_width-2:0], 1'b0};
        end
      end
      imuldiv_pkg::st_sign: begin
        // each half fixed on its own
        if (neg_quot_reg) begin
          quot_reg <= -quot_reg;
        end
        if (neg_rem_reg) begin
          rem_reg <= -rem_reg;
        end
      end
      default: begin
        // st_done holds the result under back-pressure
      end
    endcase
  end

endmodule

//--- rtl/int_mul_iterative.sv
// ------------------------------------------------
// iterative multiplier unit
// joins control and datapath at the handshake boundary
// ------------------------------------------------

`timescale 1ns/100ps

module int_mul_iterative (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [imuldiv_pkg::data_width-1:0]    req_a,
  input  logic [imuldiv_pkg::data_width-1:0]    req_b,
  input  logic                                  req_signed,
  input  logic                                  req_val,
  input  logic                                  resp_rdy,
  output logic                                  req_rdy,
  output logic [imuldiv_pkg::result_width-1:0]  resp_result,
  output logic                                  resp_val
);

  // ctrl to dpath
  logic a_en;
  logic a_mux_sel;
  logic b_en;
  logic b_mux_sel;
  logic result_en;
  logic result_mux_sel;
  logic cnt_load;
  logic sign_en;
  // dpath status back to ctrl
  logic counter_is_zero;
  logic b_lsb;

  int_mul_ctrl ctrl (
    .clk             (clk),
    .reset           (reset),
    .req_val         (req_val),
    .resp_rdy        (resp_rdy),
    .counter_is_zero (counter_is_zero),
    .b_lsb           (b_lsb),
    .req_rdy         (req_rdy),
    .resp_val        (resp_val),
    .a_en            (a_en),
    .a_mux_sel       (a_mux_sel),
    .b_en            (b_en),
    .b_mux_sel       (b_mux_sel),
    .result_en       (result_en),
    .result_mux_sel  (result_mux_sel),
    .cnt_load        (cnt_load),
    .sign_en         (sign_en)
  );

  int_mul_dpath dpath (
    .clk             (clk),
    .reset           (reset),
    .req_a           (req_a),
    .req_b           (req_b),
    .req_signed      (req_signed),
    .a_en            (a_en),
    .a_mux_sel       (a_mux_sel),
    .b_en            (b_en),
    .b_mux_sel       (b_mux_sel),
    .result_en       (result_en),
    .result_mux_sel  (result_mux_sel),
    .cnt_load        (cnt_load),
    .sign_en         (sign_en),
    .resp_result     (resp_result),
    .counter_is_zero (counter_is_zero),
    .b_lsb           (b_lsb)
  );

endmodule

//--- rtl/int_mul_ctrl.sv
// ------------------------------------------------
// iterative multiplier control
// fsm for datapath enables, mux selects and handshake
// ------------------------------------------------

`timescale 1ns/100ps

module int_mul_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  input  logic counter_is_zero,
  input  logic b_lsb,
  output logic req_rdy,
  output logic resp_val,
  output logic a_en,
  output logic a_mux_sel,
  output logic b_en,
  output logic b_mux_sel,
  output logic result_en,
  output logic result_mux_sel,
  output logic cnt_load,
  output logic sign_en
);

  imuldiv_pkg::unit_state_e state;
  imuldiv_pkg::unit_state_e state_next;

  logic accept;

  // decode from state directly, keeps req_rdy out of the loop
  assign accept = req_val && (state == imuldiv_pkg::st_idle);

  // ------------------------------------------------
  // state register and transitions
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      imuldiv_pkg::st_idle: if (accept)          state_next = imuldiv_pkg::st_calc;
      imuldiv_pkg::st_calc: if (counter_is_zero) state_next = imuldiv_pkg::st_sign;
      imuldiv_pkg::st_sign:                      state_next = imuldiv_pkg::st_done;
      imuldiv_pkg::st_done: if (resp_rdy)        state_next = imuldiv_pkg::st_idle;
      default:                                   state_next = imuldiv_pkg::st_idle;
    endcase
  end

  // ------------------------------------------------
  // output decode per state
  // ------------------------------------------------

  always_comb begin
    req_rdy        = 1'b0;
    resp_val       = 1'b0;
    a_en           = 1'b0;
    a_mux_sel      = 1'b0;
    b_en           = 1'b0;
    b_mux_sel      = 1'b0;
    result_en      = 1'b0;
    result_mux_sel = 1'b0;
    cnt_load       = 1'b0;
    sign_en        = 1'b0;
    case (state)
      imuldiv_pkg::st_idle: begin
        req_rdy   = 1'b1;
        // load magnitudes, clear accumulator, arm counter
        a_en      = accept;
        b_en      = accept;
        result_en = accept;
        cnt_load  = accept;
      end
      imuldiv_pkg::st_calc: begin
        a_en           = 1'b1;
        a_mux_sel      = 1'b1;
        b_en           = 1'b1;
        b_mux_sel      = 1'b1;
        // add only when the current multiplier bit is set
        result_en      = b_lsb;
        result_mux_sel = 1'b1;
      end
      imuldiv_pkg::st_sign: begin
        sign_en = 1'b1;
      end
      imuldiv_pkg::st_done: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

endmodule

//--- rtl/int_mul_dpath.sv
// ------------------------------------------------
// iterative multiplier datapath
// magnitude shift-and-add with a final sign fix
// ------------------------------------------------

`timescale 1ns/100ps

module int_mul_dpath (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [imuldiv_pkg::data_width-1:0]    req_a,
  input  logic [imuldiv_pkg::data_width-1:0]    req_b,
  input  logic                                  req_signed,
  input  logic                                  a_en,
  input  logic                                  a_mux_sel,
  input  logic                                  b_en,
  input  logic                                  b_mux_sel,
  input  logic                                  result_en,
  input  logic                                  result_mux_sel,
  input  logic                                  cnt_load,
  input  logic                                  sign_en,
  output logic [imuldiv_pkg::result_width-1:0]  resp_result,
  output logic                                  counter_is_zero,
  output logic                                  b_lsb
);

  logic [imuldiv_pkg::result_width-1:0]  a_reg;
  logic [imuldiv_pkg::data_width-1:0]    b_reg;
  logic [imuldiv_pkg::result_width-1:0]  result_reg;
  logic [imuldiv_pkg::counter_width-1:0] counter_reg;
  logic                                  negate_reg;

  logic [imuldiv_pkg::data_width-1:0]    a_mag;
  logic [imuldiv_pkg::data_width-1:0]    b_mag;
  logic [imuldiv_pkg::result_width-1:0]  a_mux_out;
  logic [imuldiv_pkg::data_width-1:0]    b_mux_out;
  logic [imuldiv_pkg::result_width-1:0]  result_mux_out;

  // ------------------------------------------------
  // operand magnitudes
  // ------------------------------------------------

  // unsigned ops pass the raw bits straight through
  assign a_mag = (req_signed && req_a[imuldiv_pkg::data_width-1]) ? -req_a : req_a;
  assign b_mag = (req_signed && req_b[imuldiv_pkg::data_width-1]) ? -req_b : req_b;

  // multiplicand grows left, multiplier drains right
  assign a_mux_out = a_mux_sel ? (a_reg << 1) : {{imuldiv_pkg::data_width{1'b0}}, a_mag};
  assign b_mux_out = b_mux_sel ? (b_reg >> 1) : b_mag;

  // accumulate path, 0 selects clear on load
  assign result_mux_out = result_mux_sel ? (result_reg + a_reg) : '0;

  assign b_lsb           = b_reg[0];
  assign counter_is_zero = (counter_reg == '0);
  assign resp_result     = result_reg;

  // ------------------------------------------------
  // operand and accumulator registers
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_out;
    end
    if (b_en) begin
      b_reg <= b_mux_out;
    end
    // sign fix wins over accumulate, ctrl never asserts both
    if (sign_en) begin
      result_reg <= negate_reg ? -result_reg : result_reg;
    end else if (result_en) begin
      result_reg <= result_mux_out;
    end
  end

  // step counter and product sign flag
  always_ff @(posedge clk) begin
    if (reset) begin
      counter_reg <= '0;
      negate_reg  <= 1'b0;
    end else if (cnt_load) begin
      counter_reg <= imuldiv_pkg::counter_width'(imuldiv_pkg::step_count - 1);
      // product sign is xor of operand signs
      negate_reg  <= req_signed &
                     (req_a[imuldiv_pkg::data_width-1] ^ req_b[imuldiv_pkg::data_width-1]);
    end else if (b_en) begin
      counter_reg <= counter_reg - 1'b1;
    end
  end

endmodule

//--- rtl/imuldiv_pkg.sv
// ------------------------------------------------
// imuldiv shared definitions
// widths, step count, latency, opcode and state encodings
// ------------------------------------------------

package imuldiv_pkg;

  // ------------------------------------------------
  // widths
  // ------------------------------------------------

  // operand width fixed by the instruction set
  localparam int data_width = 32;
  // response carries full product or {remainder, quotient}
  localparam int result_width = 64;

  // ------------------------------------------------
  // iteration and timing
  // ------------------------------------------------

  // one step per operand bit
  localparam int step_count = 32;
  // counter runs step_count-1 down to zero
  localparam int counter_width = 5;
  // accept edge to first resp_val cycle: 1 load + 32 steps + 1 sign
  localparam int unit_latency = 34;

  // ------------------------------------------------
  // encodings
  // ------------------------------------------------

  typedef enum logic [1:0] {
    op_mul  = 2'd0,
    op_mulu = 2'd1,
    op_div  = 2'd2,
    op_divu = 2'd3
  } muldiv_op_e;

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_sign = 2'd2,
    st_done = 2'd3
  } unit_state_e;

endpackage
